/* hw/dwc_pkg.sv */
package dwc_pkg;

  ////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////

  localparam int ADDR_W   = 32;
  localparam int LEN_W    = 8;   // also the width of the repeat count
  localparam int RESP_W   = 2;
  localparam int ID_W_MAX = 8;   // the slice structs carry the widest id the top level allows

  ////////////////////////////////////////
  // write response codes
  ////////////////////////////////////////

  // the merger ranks these by numeric value, so DECERR wins over SLVERR
  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
  localparam logic [RESP_W-1:0] RESP_EXOKAY = 2'b01;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;
  localparam logic [RESP_W-1:0] RESP_DECERR = 2'b11;

  ////////////////////////////////////////
  // register slice payloads
  ////////////////////////////////////////

  typedef struct packed {
    logic [ID_W_MAX-1:0] id;      // upper bits are zero filled by the top level
    logic [ADDR_W-1:0]   addr;
    logic [LEN_W-1:0]    len;
  } aw_beat_t;

  typedef struct packed {
    logic [ID_W_MAX-1:0] id;
    logic [RESP_W-1:0]   resp;
  } b_beat_t;

endpackage

/* hw/dwc_reg_slice.sv */
module dwc_reg_slice #(
  parameter type payload_t = logic
) (
  input  logic     ACLK,
  input  logic     ARESET,

  input  logic     s_valid,
  output logic     s_ready,
  input  payload_t s_data,

  output logic     m_valid,
  input  logic     m_ready,
  output payload_t m_data
);

  logic     open_q;
  logic     valid_q;
  payload_t data_q;

  // the slice takes a new entry when it is empty or its entry leaves this cycle
  assign s_ready = open_q & (~valid_q | m_ready);
  assign m_valid = valid_q;
  assign m_data  = data_q;

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      open_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      open_q <= 1'b1;          // input side opens on the first cycle after reset
      if (s_ready) begin
        valid_q <= s_valid;    // a bubble on the input empties the slice
      end
    end
  end

  ////////////////////////////////////////
  // payload
  ////////////////////////////////////////

  always_ff @(posedge ACLK) begin
    if (s_ready) begin
      data_q <= s_data;        // only meaningful while valid_q is set
    end
  end

endmodule

/* hw/dwc_aw_splitter.sv */
module dwc_aw_splitter import dwc_pkg::*; #(
  parameter int ID_W       = 4,
  parameter int MAX_BEATS  = 16,
  parameter int BEAT_BYTES = 4
) (
  input  logic              ACLK,
  input  logic              ARESET,

  // slave-side burst from the AW slice
  input  logic [ID_W-1:0]   s_awid,
  input  logic [ADDR_W-1:0] s_awaddr,
  input  logic [LEN_W-1:0]  s_awlen,
  input  logic              s_awvalid,
  output logic              s_awready,

  // master-side sub-bursts
  output logic [ADDR_W-1:0] m_awaddr,
  output logic [LEN_W-1:0]  m_awlen,
  output logic              m_awvalid,
  input  logic              m_awready,

  // one command per accepted burst
  output logic              cmd_valid,
  input  logic              cmd_ready,
  output logic [ID_W-1:0]   cmd_id,
  output logic              cmd_split,
  output logic [LEN_W-1:0]  cmd_repeat
);

  localparam int CNT_W = LEN_W + 1;   // a burst holds up to 256 beats
  localparam int SHIFT = $clog2(MAX_BEATS);
  localparam logic [CNT_W-1:0]  MAX_CNT = CNT_W'(MAX_BEATS);
  localparam logic [LEN_W-1:0]  MAX_LEN = LEN_W'(MAX_BEATS - 1);
  localparam logic [ADDR_W-1:0] STEP    = ADDR_W'(MAX_BEATS * BEAT_BYTES);

  logic              busy_q;
  logic [ADDR_W-1:0] addr_q;
  logic [CNT_W-1:0]  remain_q;
  logic              accept;
  logic              issue;
  logic              last_sub;

  ////////////////////////////////////////
  // burst intake and command
  ////////////////////////////////////////

  // a burst is taken only when its command can be pushed in the same cycle
  assign s_awready = ~busy_q & cmd_ready;
  assign accept    = s_awvalid & s_awready;

  assign cmd_valid  = s_awvalid & ~busy_q;
  assign cmd_id     = s_awid;
  assign cmd_split  = ({1'b0, s_awlen} >= MAX_CNT);   // more than MAX_BEATS beats
  assign cmd_repeat = s_awlen >> SHIFT;               // sub-bursts minus one

  ////////////////////////////////////////
  // sub-burst generation
  ////////////////////////////////////////

  assign issue     = m_awvalid & m_awready;
  assign last_sub  = (remain_q <= MAX_CNT);
  assign m_awvalid = busy_q;
  assign m_awaddr  = addr_q;
  assign m_awlen   = last_sub ? LEN_W'(remain_q - 1'b1) : MAX_LEN;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      busy_q <= 1'b0;
    end else if (accept) begin
      busy_q <= 1'b1;
    end else if (issue && last_sub) begin
      busy_q <= 1'b0;          // idle again once the tail sub-burst is taken
    end
  end

  always_ff @(posedge ACLK) begin
    if (accept) begin
      addr_q   <= s_awaddr;
      remain_q <= {1'b0, s_awlen} + 1'b1;
    end else if (issue) begin
      addr_q   <= addr_q + STEP;
      remain_q <= remain_q - MAX_CNT;
    end
  end

endmodule

/* hw/dwc_cmd_fifo.sv */
module dwc_cmd_fifo import dwc_pkg::*; #(
  parameter int ID_W      = 4,
  parameter int CMD_DEPTH = 4
) (
  input  logic             ACLK,
  input  logic             ARESET,

  input  logic             in_valid,
  output logic             in_ready,
  input  logic [ID_W-1:0]  in_id,
  input  logic             in_split,
  input  logic [LEN_W-1:0] in_repeat,

  output logic             out_valid,
  input  logic             out_ready,
  output logic [ID_W-1:0]  out_id,
  output logic             out_split,
  output logic [LEN_W-1:0] out_repeat
);

  localparam int PTR_W   = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
  localparam int CNT_W   = $clog2(CMD_DEPTH + 1);
  localparam int ENTRY_W = ID_W + 1 + LEN_W;

  logic [ENTRY_W-1:0] mem [CMD_DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               push;
  logic               pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(CMD_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign in_ready  = (count_q != CNT_W'(CMD_DEPTH));
  assign out_valid = (count_q != '0);
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;

  // head entry is presented straight from the array
  assign {out_id, out_split, out_repeat} = mem[rd_ptr_q];

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (push) begin
      mem[wr_ptr_q] <= {in_id, in_split, in_repeat};
    end
  end

endmodule

/* hw/dwc_b_merger.sv */
module dwc_b_merger import dwc_pkg::*; #(
  parameter int ID_W = 4
) (
  input  logic              ACLK,
  input  logic              ARESET,

  // head of the command FIFO
  input  logic              cmd_valid,
  output logic              cmd_ready,
  input  logic [ID_W-1:0]   cmd_id,
  input  logic              cmd_split,
  input  logic [LEN_W-1:0]  cmd_repeat,

  // master-side responses, one per sub-burst
  input  logic [RESP_W-1:0] m_bresp,
  input  logic              m_bvalid,
  output logic              m_bready,

  // merged slave-side response
  output logic [ID_W-1:0]   s_bid,
  output logic [RESP_W-1:0] s_bresp,
  output logic              s_bvalid,
  input  logic              s_bready
);

  logic              first_word_q;
  logic [LEN_W-1:0]  repeat_q;
  logic [LEN_W-1:0]  repeat_pre;
  logic [RESP_W-1:0] acc_q;
  logic [RESP_W-1:0] resp_merged;
  logic              last_word;
  logic              pop;

  ////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////

  assign last_word = ~cmd_split | (~first_word_q & (repeat_q == '0));

  // only the last response of a burst waits on the slave side
  assign m_bready  = cmd_valid & (s_bready | ~last_word);
  assign pop       = m_bvalid & m_bready;
  assign cmd_ready = pop & last_word;

  assign s_bvalid = m_bvalid & cmd_valid & last_word;
  assign s_bid    = cmd_id;
  assign s_bresp  = resp_merged;

  ////////////////////////////////////////
  // response accumulation
  ////////////////////////////////////////

  always_comb begin
    resp_merged = m_bresp;
    if (cmd_split && !first_word_q && (acc_q > m_bresp)) begin
      resp_merged = acc_q;     // keep the worst code seen so far
    end
  end

  always_ff @(posedge ACLK) begin
    if (pop) begin
      acc_q <= resp_merged;
    end
  end

  ////////////////////////////////////////
  // sub-burst counting
  ////////////////////////////////////////

  assign repeat_pre = first_word_q ? cmd_repeat : repeat_q;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      first_word_q <= 1'b1;
      repeat_q     <= '0;
    end else if (pop) begin
      repeat_q     <= repeat_pre - 1'b1;
      first_word_q <= last_word;   // next response starts a new burst
    end
  end

endmodule

/* hw/dwc_write_resp_top.sv */
module dwc_write_resp_top import dwc_pkg::*; #(
  parameter int ID_W       = 4,
  parameter int MAX_BEATS  = 16,
  parameter int BEAT_BYTES = 4,
  parameter int CMD_DEPTH  = 4
) (
  input  logic              ACLK,
  input  logic              ARESET,

  input  logic [ID_W-1:0]   s_awid,
  input  logic [ADDR_W-1:0] s_awaddr,
  input  logic [LEN_W-1:0]  s_awlen,
  input  logic              s_awvalid,
  output logic              s_awready,

  output logic [ID_W-1:0]   s_bid,
  output logic [RESP_W-1:0] s_bresp,
  output logic              s_bvalid,
  input  logic              s_bready,

  output logic [ADDR_W-1:0] m_awaddr,
  output logic [LEN_W-1:0]  m_awlen,
  output logic              m_awvalid,
  input  logic              m_awready,

  input  logic [RESP_W-1:0] m_bresp,
  input  logic              m_bvalid,
  output logic              m_bready
);

  aw_beat_t          aw_in;
  aw_beat_t          aw_out;
  logic              sp_awvalid;
  logic              sp_awready;

  logic              sp_cmd_valid;
  logic              sp_cmd_ready;
  logic [ID_W-1:0]   sp_cmd_id;
  logic              sp_cmd_split;
  logic [LEN_W-1:0]  sp_cmd_repeat;

  logic              mg_cmd_valid;
  logic              mg_cmd_ready;
  logic [ID_W-1:0]   mg_cmd_id;
  logic              mg_cmd_split;
  logic [LEN_W-1:0]  mg_cmd_repeat;

  logic [ID_W-1:0]   mg_bid;
  logic [RESP_W-1:0] mg_bresp;
  logic              mg_bvalid;
  logic              mg_bready;
  b_beat_t           b_in;
  b_beat_t           b_out;

  ////////////////////////////////////////
  // AW path
  ////////////////////////////////////////

  assign aw_in = '{id: ID_W_MAX'(s_awid), addr: s_awaddr, len: s_awlen};

  dwc_reg_slice #(.payload_t(aw_beat_t)) u_aw_slice (
    .ACLK, .ARESET,
    .s_valid(s_awvalid), .s_ready(s_awready), .s_data(aw_in),
    .m_valid(sp_awvalid), .m_ready(sp_awready), .m_data(aw_out)
  );

  dwc_aw_splitter #(.ID_W(ID_W), .MAX_BEATS(MAX_BEATS), .BEAT_BYTES(BEAT_BYTES)) u_splitter (
    .ACLK, .ARESET,
    .s_awid(aw_out.id[ID_W-1:0]), .s_awaddr(aw_out.addr), .s_awlen(aw_out.len),
    .s_awvalid(sp_awvalid), .s_awready(sp_awready),
    .m_awaddr, .m_awlen, .m_awvalid, .m_awready,
    .cmd_valid(sp_cmd_valid), .cmd_ready(sp_cmd_ready), .cmd_id(sp_cmd_id),
    .cmd_split(sp_cmd_split), .cmd_repeat(sp_cmd_repeat)
  );

  dwc_cmd_fifo #(.ID_W(ID_W), .CMD_DEPTH(CMD_DEPTH)) u_cmd_fifo (
    .ACLK, .ARESET,
    .in_valid(sp_cmd_valid), .in_ready(sp_cmd_ready), .in_id(sp_cmd_id),
    .in_split(sp_cmd_split), .in_repeat(sp_cmd_repeat),
    .out_valid(mg_cmd_valid), .out_ready(mg_cmd_ready), .out_id(mg_cmd_id),
    .out_split(mg_cmd_split), .out_repeat(mg_cmd_repeat)
  );

  ////////////////////////////////////////
  // B path
  ////////////////////////////////////////

  dwc_b_merger #(.ID_W(ID_W)) u_b_merger (
    .ACLK, .ARESET,
    .cmd_valid(mg_cmd_valid), .cmd_ready(mg_cmd_ready), .cmd_id(mg_cmd_id),
    .cmd_split(mg_cmd_split), .cmd_repeat(mg_cmd_repeat),
    .m_bresp, .m_bvalid, .m_bready,
    .s_bid(mg_bid), .s_bresp(mg_bresp), .s_bvalid(mg_bvalid), .s_bready(mg_bready)
  );

  assign b_in = '{id: ID_W_MAX'(mg_bid), resp: mg_bresp};

  dwc_reg_slice #(.payload_t(b_beat_t)) u_b_slice (
    .ACLK, .ARESET,
    .s_valid(mg_bvalid), .s_ready(mg_bready), .s_data(b_in),
    .m_valid(s_bvalid), .m_ready(s_bready), .m_data(b_out)
  );

  assign s_bid   = b_out.id[ID_W-1:0];
  assign s_bresp = b_out.resp;

endmodule

/* bench/dwc_asserts.sv */
module dwc_b_merger_asserts import dwc_pkg::*; #(
  parameter int ID_W = 4
) (
  input logic              ACLK,
  input logic              ARESET,
  input logic              cmd_valid,
  input logic              cmd_ready,
  input logic [LEN_W-1:0]  cmd_repeat,
  input logic              m_bvalid,
  input logic              m_bready,
  input logic [ID_W-1:0]   s_bid,
  input logic [RESP_W-1:0] s_bresp,
  input logic              s_bvalid,
  input logic              s_bready
);

  int unsigned fail_count = 0;
  logic [LEN_W-1:0] taken_q;   // responses already taken for the head command

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      taken_q <= '0;
    end else if (cmd_ready) begin
      taken_q <= '0;
    end else if (m_bvalid && m_bready) begin
      taken_q <= taken_q + 1'b1;
    end
  end

  // the last response of a burst is taken only when the slave side can accept it
  a_bready_needs_cmd: assert property (@(posedge ACLK) disable iff (ARESET)
    m_bready |-> cmd_valid && (s_bready || (taken_q != cmd_repeat)))
  else begin
    fail_count++;
    $error("m_bready is high with no command or on a last response the slave side refuses");
  end

  // a raised response holds until the slave side takes it
  a_b_stable: assert property (@(posedge ACLK) disable iff (ARESET)
    s_bvalid && !s_bready |=> s_bvalid && $stable(s_bid) && $stable(s_bresp))
  else begin
    fail_count++;
    $error("s_bvalid dropped or its payload moved before s_bready");
  end

  a_pop_on_b: assert property (@(posedge ACLK) disable iff (ARESET)
    cmd_ready |-> s_bvalid && s_bready && (taken_q == cmd_repeat))
  else begin
    fail_count++;
    $error("the command was popped without the final slave response transfer");
  end

endmodule

bind dwc_b_merger dwc_b_merger_asserts #(.ID_W(ID_W)) u_asserts (
  .ACLK(ACLK), .ARESET(ARESET),
  .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_repeat(cmd_repeat),
  .m_bvalid(m_bvalid), .m_bready(m_bready),
  .s_bid(s_bid), .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready)
);

/* bench/tb_dwc.sv */
module tb_dwc import dwc_pkg::*; ();

  localparam int ID_W         = 4;
  localparam int MAX_BEATS    = 16;
  localparam int BEAT_BYTES   = 4;
  localparam int CMD_DEPTH    = 4;
  localparam int N_BURSTS     = 300;
  localparam int HOLD_CYCLES  = 400;
  localparam int IDLE_LIMIT   = 2000;
  localparam int DRAIN_CYCLES = 50;
  localparam int OUT_BOUND    = CMD_DEPTH + 2;   // AW slice, full FIFO and B slice
  localparam int ALIGN        = $clog2(BEAT_BYTES);

  logic ACLK, ARESET;
  logic [ID_W-1:0] s_awid, s_bid;
  logic [ADDR_W-1:0] s_awaddr, m_awaddr;
  logic [LEN_W-1:0] s_awlen, m_awlen;
  logic [RESP_W-1:0] s_bresp, m_bresp;
  logic s_awvalid, s_awready, s_bvalid, s_bready;
  logic m_awvalid, m_awready, m_bvalid, m_bready;

  logic [31:0] lfsr = 32'hc230f1d1;
  logic aw_fire, maw_fire, mb_fire, sb_fire, hold, hold_done;
  logic [RESP_W-1:0] acc;
  int n_sent, n_done, owed, seen, idle, hold_cnt;
  logic [ADDR_W-1:0] exp_addr[$];
  logic [LEN_W-1:0] exp_len[$];
  int burst_subs[$];
  logic [ID_W-1:0] burst_ids[$], exp_bid[$];
  logic [RESP_W-1:0] exp_bresp[$];

  dwc_write_resp_top #(
    .ID_W(ID_W), .MAX_BEATS(MAX_BEATS), .BEAT_BYTES(BEAT_BYTES), .CMD_DEPTH(CMD_DEPTH)
  ) dut0 (
    .ACLK(ACLK), .ARESET(ARESET),
    .s_awid(s_awid), .s_awaddr(s_awaddr), .s_awlen(s_awlen),
    .s_awvalid(s_awvalid), .s_awready(s_awready),
    .s_bid(s_bid), .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
    .m_awaddr(m_awaddr), .m_awlen(m_awlen), .m_awvalid(m_awvalid), .m_awready(m_awready),
    .m_bresp(m_bresp), .m_bvalid(m_bvalid), .m_bready(m_bready)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] rnd(input int nbits);
    logic [31:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // taps 32, 22, 2, 1
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      abort_run("a DUT output did not match the model");
    end
  endtask

  ////////////////////////////////////////
  // model and checks, sampled mid-cycle
  ////////////////////////////////////////

  task automatic sample_cycle();
    logic [ADDR_W-1:0] a;
    int beats;
    int subs;
    if (dut0.u_b_merger.u_asserts.fail_count != 0) begin
      abort_run("a B merger assertion failed");
    end
    aw_fire  = s_awvalid && s_awready;
    maw_fire = m_awvalid && m_awready;
    mb_fire  = m_bvalid && m_bready;
    sb_fire  = s_bvalid && s_bready;
    idle++;
    if (sb_fire) begin
      if (exp_bid.size() == 0) begin
        abort_run("a slave response came out with no completed burst behind it");
      end
      check_value("s_bid", exp_bid.pop_front(), s_bid);
      check_value("s_bresp", exp_bresp.pop_front(), s_bresp);
      n_done++;
      idle = 0;
    end
    if (mb_fire) begin
      if (burst_subs.size() == 0) begin
        abort_run("a master response was taken with no burst waiting for it");
      end
      acc = (seen == 0 || m_bresp > acc) ? m_bresp : acc;   // worst code wins
      seen++;
      if (seen == burst_subs[0]) begin
        exp_bid.push_back(burst_ids.pop_front());
        exp_bresp.push_back(acc);
        burst_subs.delete(0);
        seen = 0;
      end
    end
    if (maw_fire) begin
      if (exp_addr.size() == 0) begin
        abort_run("a master sub-burst was issued that no slave burst asked for");
      end
      check_value("m_awaddr", exp_addr.pop_front(), m_awaddr);
      check_value("m_awlen", exp_len.pop_front(), m_awlen);
      owed++;
    end
    if (aw_fire) begin
      a = s_awaddr;
      beats = int'(s_awlen) + 1;
      subs = 0;
      while (beats > 0) begin
        exp_addr.push_back(a);
        exp_len.push_back(LEN_W'(beats > MAX_BEATS ? MAX_BEATS - 1 : beats - 1));
        a = a + ADDR_W'(MAX_BEATS * BEAT_BYTES);
        beats = beats - MAX_BEATS;
        subs++;
      end
      burst_subs.push_back(subs);
      burst_ids.push_back(s_awid);
      n_sent++;
      idle = 0;
    end
    check_value("outstanding within bound", 1, (n_sent - n_done) <= OUT_BOUND);
    if (!hold && !hold_done && n_sent >= N_BURSTS / 2) begin
      hold = 1'b1;                 // withhold master responses for a while
    end else if (hold) begin
      hold_cnt++;
      if (hold_cnt == HOLD_CYCLES) begin
        check_value("outstanding while held", CMD_DEPTH + 1, n_sent - n_done);
        check_value("s_awready while held", 0, s_awready);
        hold = 1'b0;
        hold_done = 1'b1;
        idle = 0;
      end
    end
    if (!hold && idle > IDLE_LIMIT) begin
      abort_run("the DUT made no progress for too many cycles");
    end
  endtask

  ////////////////////////////////////////
  // stimulus, driven just after the edge
  ////////////////////////////////////////

  task automatic drive_cycle();
    if (!s_awvalid || aw_fire) begin
      s_awvalid = 1'b0;
      if (n_sent < N_BURSTS && rnd(2) != 0) begin
        s_awvalid = 1'b1;
        s_awid    = ID_W'(rnd(ID_W));
        s_awaddr  = ADDR_W'(rnd(ADDR_W - ALIGN) << ALIGN);
        case (rnd(2))
          2: s_awlen = LEN_W'(rnd(LEN_W));
          3: s_awlen = LEN_W'(MAX_BEATS - 4 + rnd(3));   // just around the split point
          default: s_awlen = LEN_W'(rnd($clog2(MAX_BEATS)));
        endcase
      end
    end
    m_awready = (rnd(1) != 0);
    if (!m_bvalid || mb_fire) begin
      m_bvalid = 1'b0;
      if (owed > 0 && !hold && rnd(2) != 0) begin
        m_bvalid = 1'b1;
        m_bresp  = RESP_W'(rnd(RESP_W));
        owed--;
      end
    end
    s_bready = (rnd(1) != 0);
  endtask

  task automatic run_cycle();
    @(negedge ACLK);
    sample_cycle();
    @(posedge ACLK);
    #2;
    drive_cycle();
  endtask

  initial begin
    ACLK = 1'b0;
    forever #10 ACLK = ~ACLK;
  end

  initial begin
    ARESET = 1'b1;
    s_awid = '0;
    s_awaddr = '0;
    s_awlen = '0;
    s_awvalid = 1'b0;
    s_bready = 1'b0;
    m_awready = 1'b0;
    m_bresp = RESP_OKAY;
    m_bvalid = 1'b0;
    {aw_fire, maw_fire, mb_fire, sb_fire, hold, hold_done} = '0;
    {n_sent, n_done, owed, seen, idle, hold_cnt} = '0;
    acc = RESP_OKAY;
    repeat (10) @(posedge ACLK);
    #2;
    ARESET = 1'b0;
    while (n_done < N_BURSTS) begin
      run_cycle();
    end
    // a quiet tail catches any extra sub-burst or response
    repeat (DRAIN_CYCLES) begin
      run_cycle();
    end
    check_value("s_bvalid after the last burst", 0, s_bvalid);
    check_value("m_awvalid after the last burst", 0, m_awvalid);
    $display("All tests passed");
    $finish;
  end

endmodule

/* verilog.f */
hw/dwc_pkg.sv
hw/dwc_reg_slice.sv
hw/dwc_aw_splitter.sv
hw/dwc_cmd_fifo.sv
hw/dwc_b_merger.sv
hw/dwc_write_resp_top.sv
bench/dwc_asserts.sv
bench/tb_dwc.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_dwc -o tb_dwc
	./obj_dir/tb_dwc | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
